// File: hamming_pkg.sv
package hamming_pkg;

    // Widest codeword. It also sets the AXI4-Lite data width.
    localparam int max_n = 32;

    // Most check rows of any supported code.
    localparam int max_p = 6;

    // Width of a bit position inside the widest codeword.
    localparam int err_pos_w = $clog2(max_n);

    // Register address width on the AXI4-Lite side.
    localparam int addr_w = 4;

    // Code mode: 0 is (8,4), 1 is (16,11), 2 is (32,26), 3 is reserved.
    typedef logic [1:0] mode_t;

    // Codeword length and parity count per mode. The reserved mode maps to zero.
    localparam int code_n [4] = '{8, 16, 32, 0};
    localparam int code_p [4] = '{4, 5, 6, 0};

    // H rows per mode, zero-extended to max_n bits.
    // Row 0 is the overall parity row. Each later row has one identity bit in the
    // low p positions, so the parity bits sit below the info bits.
    localparam logic [max_n-1:0] h_row [4][max_p] = '{
        '{
            32'h0000_00ff, 32'h0000_00e4, 32'h0000_00d2,
            32'h0000_00b1, 32'h0000_0000, 32'h0000_0000
        },
        '{
            32'h0000_ffff, 32'h0000_fe08, 32'h0000_f1c4,
            32'h0000_cda2, 32'h0000_ab61, 32'h0000_0000
        },
        '{
            32'hffff_ffff, 32'hfffe_0010, 32'hff01_fc08,
            32'hf0f1_e384, 32'hcccd_9b42, 32'haaab_56c1
        },
        '{
            32'h0000_0000, 32'h0000_0000, 32'h0000_0000,
            32'h0000_0000, 32'h0000_0000, 32'h0000_0000
        }
    };

    // Register map.
    localparam logic [addr_w-1:0] addr_codeword = 4'h0;
    localparam logic [addr_w-1:0] addr_mode     = 4'h4;
    localparam logic [addr_w-1:0] addr_data     = 4'h8;
    localparam logic [addr_w-1:0] addr_status   = 4'hc;

    // Status register fields. The error position spans bits 8 to 12.
    localparam int status_done          = 0;
    localparam int status_corrected     = 1;
    localparam int status_uncorrectable = 2;
    localparam int status_err_pos       = 8;

    // AXI response codes.
    localparam logic [1:0] axil_resp_okay   = 2'b00;
    localparam logic [1:0] axil_resp_slverr = 2'b10;

endpackage

// File: decode_result_if.sv
`timescale 1ns/1ps

interface decode_result_if;

    // One-cycle pulse that qualifies the rest of the bundle.
    logic                                 valid;
    // Info bits, right-aligned.
    logic [hamming_pkg::max_n-1:0]        data;
    logic                                 corrected;
    logic                                 uncorrectable;
    logic [hamming_pkg::err_pos_w-1:0]    err_pos;

    modport locator (output valid, data, corrected, uncorrectable, err_pos);
    modport regs    (input  valid, data, corrected, uncorrectable, err_pos);

endinterface

// File: axil_decoder_regs.sv
`timescale 1ns/1ps

module axil_decoder_regs (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [hamming_pkg::addr_w-1:0]     awaddr,
    input  logic                               awvalid,
    output logic                               awready,
    input  logic [hamming_pkg::max_n-1:0]      wdata,
    input  logic [hamming_pkg::max_n/8-1:0]    wstrb,
    input  logic                               wvalid,
    output logic                               wready,
    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  logic                               bready,
    input  logic [hamming_pkg::addr_w-1:0]     araddr,
    input  logic                               arvalid,
    output logic                               arready,
    output logic [hamming_pkg::max_n-1:0]      rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  logic                               rready,
    output logic                               start,
    output logic [hamming_pkg::max_n-1:0]      codeword,
    output hamming_pkg::mode_t                 mode,
    decode_result_if.regs                      res
);

    logic                                 wr_fire;
    logic                                 rd_fire;
    logic [hamming_pkg::max_n-1:0]        cw_q;
    logic [hamming_pkg::max_n-1:0]        cw_merged;
    hamming_pkg::mode_t                   mode_q;
    logic [hamming_pkg::max_n-1:0]        data_q;
    logic                                 done_q;
    logic                                 corrected_q;
    logic                                 uncorrectable_q;
    logic [hamming_pkg::err_pos_w-1:0]    err_pos_q;
    logic [hamming_pkg::max_n-1:0]        status_word;
    logic [hamming_pkg::max_n-1:0]        rd_word;

    function automatic logic is_mapped(input logic [hamming_pkg::addr_w-1:0] addr);
        return addr == hamming_pkg::addr_codeword || addr == hamming_pkg::addr_mode ||
               addr == hamming_pkg::addr_data || addr == hamming_pkg::addr_status;
    endfunction

    // A write completes in the one cycle where both ready lines are high.
    assign wr_fire = awready && awvalid && wready && wvalid;
    assign rd_fire = arready && arvalid;

    // Byte strobes merge the new word into the last codeword written.
    always_comb begin
        for (int b = 0; b < hamming_pkg::max_n / 8; b++) begin
            cw_merged[8*b +: 8] = wstrb[b] ? wdata[8*b +: 8] : cw_q[8*b +: 8];
        end
    end

    assign start    = wr_fire && (awaddr == hamming_pkg::addr_codeword);
    assign codeword = cw_merged;
    assign mode     = mode_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            // Ready is raised for a single cycle once both channels present data.
            awready <= !awready && awvalid && wvalid && !bvalid;
            wready  <= !awready && awvalid && wvalid && !bvalid;
            arready <= !arready && arvalid && !rvalid;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= is_mapped(awaddr) ? hamming_pkg::axil_resp_okay
                                       : hamming_pkg::axil_resp_slverr;
        end
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= is_mapped(araddr) ? hamming_pkg::axil_resp_okay
                                       : hamming_pkg::axil_resp_slverr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mode_q          <= '0;
            done_q          <= 1'b0;
            corrected_q     <= 1'b0;
            uncorrectable_q <= 1'b0;
            err_pos_q       <= '0;
        end else begin
            if (wr_fire && awaddr == hamming_pkg::addr_mode && wstrb[0]) begin
                mode_q <= wdata[1:0];
            end
            if (res.valid) begin
                corrected_q     <= res.corrected;
                uncorrectable_q <= res.uncorrectable;
                err_pos_q       <= res.err_pos;
            end
            // A new job hides any older result that lands in the same cycle.
            if (start) begin
                done_q <= 1'b0;
            end else if (res.valid) begin
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cw_q <= cw_merged;
        end
        if (res.valid) begin
            data_q <= res.data;
        end
    end

    always_comb begin
        status_word = '0;
        status_word[hamming_pkg::status_done]          = done_q;
        status_word[hamming_pkg::status_corrected]     = corrected_q;
        status_word[hamming_pkg::status_uncorrectable] = uncorrectable_q;
        status_word[hamming_pkg::status_err_pos +: hamming_pkg::err_pos_w] = err_pos_q;
    end

    always_comb begin
        case (araddr)
            hamming_pkg::addr_codeword: rd_word = cw_q;
            hamming_pkg::addr_mode:     rd_word = {{(hamming_pkg::max_n-2){1'b0}}, mode_q};
            hamming_pkg::addr_data:     rd_word = data_q;
            hamming_pkg::addr_status:   rd_word = status_word;
            default:                    rd_word = '0;
        endcase
    end

endmodule

// File: codeword_stage.sv
`timescale 1ns/1ps

module codeword_stage (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start,
    input  logic [hamming_pkg::max_n-1:0]    codeword,
    input  hamming_pkg::mode_t               mode,
    output logic                             job_valid,
    output logic [hamming_pkg::max_n-1:0]    job_word,
    output hamming_pkg::mode_t               job_mode
);

    logic [hamming_pkg::max_n-1:0] len_mask;

    // Keep only the bits that belong to the selected code length.
    always_comb begin
        for (int i = 0; i < hamming_pkg::max_n; i++) begin
            len_mask[i] = i < hamming_pkg::code_n[mode];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            job_valid <= 1'b0;
        end else begin
            job_valid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            job_word <= codeword & len_mask;
            job_mode <= mode;
        end
    end

endmodule

// File: parity_check_row.sv
`timescale 1ns/1ps

module parity_check_row #(
    parameter int row_index = 0
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             job_valid,
    input  logic [hamming_pkg::max_n-1:0]    job_word,
    input  hamming_pkg::mode_t               job_mode,
    output logic                             syn_bit,
    output logic                             syn_valid
);

    logic [hamming_pkg::max_n-1:0] row_mask;
    logic                          in_use;

    assign row_mask = hamming_pkg::h_row[job_mode][row_index];
    // Smaller codes leave the upper rows idle.
    assign in_use   = row_index < hamming_pkg::code_p[job_mode];

    always_ff @(posedge clk) begin
        if (rst) begin
            syn_valid <= 1'b0;
        end else begin
            syn_valid <= job_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (job_valid) begin
            syn_bit <= in_use && (^(job_word & row_mask));
        end
    end

endmodule

// File: error_locator.sv
`timescale 1ns/1ps

module error_locator (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [hamming_pkg::max_p-1:0]    syn,
    input  logic                             syn_valid,
    input  logic [hamming_pkg::max_n-1:0]    job_word,
    input  hamming_pkg::mode_t               job_mode,
    decode_result_if.locator                 res
);

    logic [hamming_pkg::max_n-1:0]        word_d;
    hamming_pkg::mode_t                   mode_d;
    logic [hamming_pkg::max_p-1:0]        col;
    logic                                 match_found;
    logic [hamming_pkg::err_pos_w-1:0]    match_pos;
    logic [hamming_pkg::max_n-1:0]        fixed_word;
    logic                                 is_corrected;
    logic                                 is_uncorrectable;

    // The rows take one cycle, so the word and mode are held back by one to match.
    always_ff @(posedge clk) begin
        word_d <= job_word;
        mode_d <= job_mode;
    end

    // Search for the H column that equals the syndrome.
    always_comb begin
        match_found = 1'b0;
        match_pos   = '0;
        col         = '0;
        for (int c = 0; c < hamming_pkg::max_n; c++) begin
            for (int r = 0; r < hamming_pkg::max_p; r++) begin
                col[r] = hamming_pkg::h_row[mode_d][r][c];
            end
            if (!match_found && c < hamming_pkg::code_n[mode_d] && col == syn) begin
                match_found = 1'b1;
                match_pos   = c[hamming_pkg::err_pos_w-1:0];
            end
        end
    end

    always_comb begin
        fixed_word       = word_d;
        is_corrected     = 1'b0;
        is_uncorrectable = 1'b0;
        if (mode_d == 2'd3) begin
            fixed_word       = '0;
            is_uncorrectable = 1'b1;
        end else if (syn != '0) begin
            // Odd overall parity points at a single flipped bit.
            if (syn[0] && match_found) begin
                fixed_word[match_pos] = ~word_d[match_pos];
                is_corrected          = 1'b1;
            end else begin
                is_uncorrectable = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= syn_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (syn_valid) begin
            res.data          <= fixed_word >> hamming_pkg::code_p[mode_d];
            res.corrected     <= is_corrected;
            res.uncorrectable <= is_uncorrectable;
            res.err_pos       <= is_corrected ? match_pos : '0;
        end
    end

endmodule

// File: secded_decoder_top.sv
`timescale 1ns/1ps

module secded_decoder_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [hamming_pkg::addr_w-1:0]     awaddr,
    input  logic                               awvalid,
    output logic                               awready,
    input  logic [hamming_pkg::max_n-1:0]      wdata,
    input  logic [hamming_pkg::max_n/8-1:0]    wstrb,
    input  logic                               wvalid,
    output logic                               wready,
    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  logic                               bready,
    input  logic [hamming_pkg::addr_w-1:0]     araddr,
    input  logic                               arvalid,
    output logic                               arready,
    output logic [hamming_pkg::max_n-1:0]      rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  logic                               rready
);

    logic                             start;
    logic [hamming_pkg::max_n-1:0]    codeword;
    hamming_pkg::mode_t               mode;
    logic                             job_valid;
    logic [hamming_pkg::max_n-1:0]    job_word;
    hamming_pkg::mode_t               job_mode;
    logic [hamming_pkg::max_p-1:0]    syn;
    logic [hamming_pkg::max_p-1:0]    row_valid;

    decode_result_if res_if ();

    axil_decoder_regs i_axil_decoder_regs (
        .clk      (clk),
        .rst      (rst),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .start    (start),
        .codeword (codeword),
        .mode     (mode),
        .res      (res_if.regs)
    );

    codeword_stage i_codeword_stage (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .codeword  (codeword),
        .mode      (mode),
        .job_valid (job_valid),
        .job_word  (job_word),
        .job_mode  (job_mode)
    );

    // One check row per syndrome bit, all fed the same job.
    for (genvar g = 0; g < hamming_pkg::max_p; g++) begin : g_row
        parity_check_row #(
            .row_index (g)
        ) i_parity_check_row (
            .clk       (clk),
            .rst       (rst),
            .job_valid (job_valid),
            .job_word  (job_word),
            .job_mode  (job_mode),
            .syn_bit   (syn[g]),
            .syn_valid (row_valid[g])
        );
    end

    // All rows run in lockstep, so row 0 speaks for the set.
    error_locator i_error_locator (
        .clk       (clk),
        .rst       (rst),
        .syn       (syn),
        .syn_valid (row_valid[0]),
        .job_word  (job_word),
        .job_mode  (job_mode),
        .res       (res_if.locator)
    );

endmodule

// File: tb_secded_decoder.sv
`timescale 1ns/1ps

module tb_secded_decoder;

    localparam int num_random    = 90;
    localparam int txn_per_job   = 6;
    localparam int max_cycles    = (num_random + 20) * txn_per_job * 20;

    logic clk;
    logic rst;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    integer      seed = 32'h1ce1;
    int          cycles = 0;
    logic [31:0] r;
    logic [31:0] last_status;
    logic [31:0] last_data;
    logic [31:0] saved_status;
    logic [31:0] saved_data;
    logic [31:0] rd_value;
    logic [1:0]  resp;

    secded_decoder_top i_secded_decoder_top (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            fail_run($sformatf("timeout: tests still running after %0d cycles", cycles));
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            fail_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // The host task is entered on a falling edge and returns on one.
    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              output logic [1:0] bresp_out);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(negedge clk); while (!(awready && wready));
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        bresp_out = bresp;
        bready    = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                             output logic [1:0] rresp_out);
        araddr  = addr;
        arvalid = 1'b1;
        do @(negedge clk); while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        data      = rdata;
        rresp_out = rresp;
        rready    = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    function automatic logic [31:0] low_mask(input int width);
        if (width >= 32) begin
            return '1;
        end
        return (32'd1 << width) - 32'd1;
    endfunction

    // Systematic encoder. Each identity column fixes one parity bit, and the overall
    // parity takes the single low position that no other row claims.
    function automatic logic [31:0] encode_word(input hamming_pkg::mode_t m,
                                                input logic [31:0] info);
        int          p;
        logic [31:0] word;
        logic [31:0] claimed;
        p       = hamming_pkg::code_p[m];
        word    = info << p;
        claimed = '0;
        for (int row = 1; row < p; row++) begin
            for (int j = 0; j < p; j++) begin
                if (hamming_pkg::h_row[m][row][j]) begin
                    word[j]    = ^(word & hamming_pkg::h_row[m][row]);
                    claimed[j] = 1'b1;
                end
            end
        end
        for (int j = 0; j < p; j++) begin
            if (!claimed[j]) begin
                word[j] = ^(word & hamming_pkg::h_row[m][0]);
            end
        end
        return word;
    endfunction

    task automatic run_job(input logic [31:0] word);
        axil_write(hamming_pkg::addr_codeword, word, resp);
        check_value("codeword_bresp", 32'(hamming_pkg::axil_resp_okay), 32'(resp));
        // The first status read lands before the pipeline has finished.
        axil_read(hamming_pkg::addr_status, last_status, resp);
        check_value("done_cleared", 32'd0, 32'(last_status[hamming_pkg::status_done]));
        while (!last_status[hamming_pkg::status_done]) begin
            axil_read(hamming_pkg::addr_status, last_status, resp);
        end
        axil_read(hamming_pkg::addr_data, last_data, resp);
        check_value("data_rresp", 32'(hamming_pkg::axil_resp_okay), 32'(resp));
    endtask

    task automatic decode_and_check(input string name, input hamming_pkg::mode_t m,
                                    input logic [31:0] info_raw, input int nflips,
                                    input logic [31:0] upper);
        int          n;
        int          k;
        int          pos1;
        int          pos2;
        logic [31:0] info;
        logic [31:0] word;
        n    = hamming_pkg::code_n[m];
        k    = n - hamming_pkg::code_p[m];
        info = info_raw & low_mask(k);
        word = encode_word(m, info);
        r    = $random(seed);
        pos1 = r % n;
        pos2 = pos1;
        while (pos2 == pos1) begin
            r    = $random(seed);
            pos2 = r % n;
        end
        if (nflips >= 1) word[pos1] = ~word[pos1];
        if (nflips == 2) word[pos2] = ~word[pos2];
        word = word | (upper & ~low_mask(n));
        axil_write(hamming_pkg::addr_mode, 32'(m), resp);
        run_job(word);
        check_value({name, "_corrected"}, 32'(nflips == 1),
                    32'(last_status[hamming_pkg::status_corrected]));
        check_value({name, "_uncorrectable"}, 32'(nflips == 2),
                    32'(last_status[hamming_pkg::status_uncorrectable]));
        if (nflips < 2) check_value({name, "_data"}, info, last_data);
        if (nflips == 1) begin
            check_value({name, "_err_pos"}, 32'(pos1),
                        32'(last_status[hamming_pkg::status_err_pos +: 5]));
        end
    endtask

    initial begin
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // Handshake outputs stay low until the host drives a request.
        check_value("reset_handshake", 32'd0,
                    32'({awready, wready, bvalid, arready, rvalid}));

        for (int m = 0; m < 4; m++) begin
            axil_write(hamming_pkg::addr_mode, 32'(m), resp);
            axil_read(hamming_pkg::addr_mode, rd_value, resp);
            check_value("mode_readback", 32'(m), rd_value);
        end

        for (int m = 0; m < 3; m++) begin
            r = $random(seed);
            decode_and_check("clean", hamming_pkg::mode_t'(m), r, 0, 32'd0);
        end

        // Garbage above the code length must not change the decode.
        for (int m = 0; m < 2; m++) begin
            r = $random(seed);
            rd_value = r;
            r = $random(seed);
            decode_and_check("upper_a", hamming_pkg::mode_t'(m), rd_value, 0, r);
            saved_status = last_status;
            saved_data   = last_data;
            r = $random(seed);
            decode_and_check("upper_b", hamming_pkg::mode_t'(m), rd_value, 0, r);
            check_value("upper_same_status", saved_status, last_status);
            check_value("upper_same_data", saved_data, last_data);
        end

        axil_write(hamming_pkg::addr_mode, 32'd3, resp);
        r = $random(seed);
        run_job(r);
        check_value("mode3_uncorrectable", 32'd1,
                    32'(last_status[hamming_pkg::status_uncorrectable]));
        check_value("mode3_data", 32'd0, last_data);

        axil_write(4'h2, 32'h1234_5678, resp);
        check_value("unmapped_bresp", 32'(hamming_pkg::axil_resp_slverr), 32'(resp));
        axil_read(4'h7, rd_value, resp);
        check_value("unmapped_rresp", 32'(hamming_pkg::axil_resp_slverr), 32'(resp));
        check_value("unmapped_rdata", 32'd0, rd_value);

        for (int t = 0; t < num_random; t++) begin
            int          m;
            int          nflips;
            logic [31:0] info;
            r      = $random(seed);
            m      = r % 3;
            r      = $random(seed);
            nflips = r % 3;
            info   = $random(seed);
            r      = $random(seed);
            decode_and_check("random", hamming_pkg::mode_t'(m), info, nflips, r);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: sim.f
hamming_pkg.sv
decode_result_if.sv
axil_decoder_regs.sv
codeword_stage.sv
parity_check_row.sv
error_locator.sv
secded_decoder_top.sv
tb_secded_decoder.sv

// File: Makefile
all: obj_dir/Vtb_secded_decoder

obj_dir/Vtb_secded_decoder: sim.f $(wildcard *.sv)
	verilator --binary --timing --assert -f sim.f --top-module tb_secded_decoder

run: obj_dir/Vtb_secded_decoder
	./obj_dir/Vtb_secded_decoder

clean:
	rm -rf obj_dir

.PHONY: all run clean
